// ==== all.f ====
source/stream_pkg.sv
source/lane_pkg.sv
source/stream_queue.sv
source/stream_router.sv
source/stream_merger.sv
source/stream_switch.sv
test/clock_gen.sv
test/stream_switch_properties.sv
test/stream_switch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the stream switch testbench with Verilator and run it
verilator --binary --timing --assert -f all.f --top-module stream_switch_tb -o sim_stream_switch \
    && ./obj_dir/sim_stream_switch \
    || exit 1

// ==== source/lane_pkg.sv ====
// Lane configuration package with the lane count, queue depth and lane limit
package lane_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Switch sizing defaults
    ////////////////////////////////////////////////////////////////////////////

    localparam int default_lanes    = 4;            // Queues behind the router
    localparam int default_capacity = 16;           // Beats per queue, at least 4

    // Highest lane count that tdest can address
    localparam int max_lanes = 2 ** stream_pkg::dest_width;

endpackage

// ==== source/stream_merger.sv ====
// Packet-aware round-robin merger draining the lane queues onto one output stream
`timescale 1ns/10ps

module stream_merger #(
    parameter int lanes = lane_pkg::default_lanes
) (
    input  logic                          aclk,
    input  logic                          areset_n,
    input  logic [lanes-1:0]              q_out_tvalid,
    input  stream_pkg::beat_t [lanes-1:0] q_out_beat,
    output logic [lanes-1:0]              q_out_tready,
    output logic                          tx_tvalid,
    output stream_pkg::data_t             tx_tdata,
    output stream_pkg::dest_t             tx_tdest,
    output logic                          tx_tlast,
    input  logic                          tx_tready
);
    stream_pkg::dest_t grant;                       // Lane currently forwarded
    stream_pkg::dest_t next_grant;
    stream_pkg::beat_t tx_beat;
    logic              packet_open;                 // Inside a multi-beat packet
    logic              handshake;
    int                cand;

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin search
    ////////////////////////////////////////////////////////////////////////////

    // Walk from farthest to nearest so the lane right after grant wins
    always_comb begin
        next_grant = grant;
        cand       = 0;
        for (int i = lanes; i >= 1; i--) begin
            cand = (int'(grant) + i) % lanes;
            if (q_out_tvalid[cand]) begin
                next_grant = stream_pkg::dest_t'(cand);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Grant register
    ////////////////////////////////////////////////////////////////////////////

    assign handshake = tx_tvalid && tx_tready;

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            grant       <= '0;
            packet_open <= 1'b0;
        end else begin
            if (handshake) begin
                packet_open <= !tx_tlast;
                if (tx_tlast) begin
                    grant <= next_grant;            // Packet done, move on
                end
            end else if (!q_out_tvalid[grant] && !packet_open) begin
                grant <= next_grant;                // Idle lane, look elsewhere
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////////////////////////////////

    assign tx_beat   = q_out_beat[grant];
    assign tx_tvalid = q_out_tvalid[grant];
    assign tx_tdata  = tx_beat.tdata;
    assign tx_tdest  = tx_beat.tdest;
    assign tx_tlast  = tx_beat.tlast;

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            q_out_tready[i] = tx_tready && (grant == stream_pkg::dest_t'(i));
        end
    end

endmodule

// ==== source/stream_pkg.sv ====
// Stream payload package with the tdata and tdest widths and the packed beat word
package stream_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int data_width = 32;                 // One tdata word
    localparam int dest_width = 2;                  // Lane address field

    ////////////////////////////////////////////////////////////////////////////
    // Field and beat types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [data_width-1:0] data_t;
    typedef logic [dest_width-1:0] dest_t;

    // One beat as stored in the queues and forwarded by the merger
    typedef struct packed {
        data_t tdata;
        dest_t tdest;
        logic  tlast;                               // End of packet
    } beat_t;

endpackage

// ==== source/stream_queue.sv ====
// Per-lane AXI4-Stream queue with registered write, almost-full ready and read FSM
`timescale 1ns/10ps

module stream_queue #(
    parameter int capacity = lane_pkg::default_capacity
) (
    input  logic              aclk,
    input  logic              areset_n,
    input  logic              rx_tvalid,
    input  stream_pkg::beat_t rx_beat,
    output logic              rx_tready,
    output logic              tx_tvalid,
    output stream_pkg::beat_t tx_beat,
    input  logic              tx_tready
);
    localparam int addr_width  = $clog2(capacity);
    localparam int count_width = $clog2(capacity + 1);

    if (capacity < 4) begin : g_capacity_check
        $error("stream_queue capacity must be at least 4");
    end

    typedef enum logic [0:0] {
        fsm_idle,
        fsm_data
    } fsm_state_t;

    stream_pkg::beat_t mem [capacity];

    logic                   write;                  // Registered input handshake
    stream_pkg::beat_t      write_data;
    logic                   read;
    stream_pkg::beat_t      read_data;
    logic [addr_width-1:0]  wr_ptr;
    logic [addr_width-1:0]  rd_ptr;
    logic [count_width-1:0] count;
    logic                   empty;
    logic                   almost_full;
    fsm_state_t             fsm_state;

    assign empty       = (count == '0);
    assign almost_full = (count >= count_width'(capacity - 2)); // Room for one beat in flight

    ////////////////////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            write     <= 1'b0;
            rx_tready <= 1'b0;
        end else begin
            write     <= rx_tvalid && rx_tready;
            rx_tready <= !almost_full;
        end
    end

    always_ff @(posedge aclk) begin
        write_data <= rx_beat;
        if (write) begin
            mem[wr_ptr] <= write_data;
        end
        if (read) begin
            read_data <= mem[rd_ptr];               // One cycle read latency
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and fill count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (write) begin
                wr_ptr <= (wr_ptr == addr_width'(capacity - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (read) begin
                rd_ptr <= (rd_ptr == addr_width'(capacity - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({write, read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Both or neither
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            fsm_state <= fsm_idle;
        end else begin
            case (fsm_state)
                fsm_idle: begin
                    if (!empty) begin
                        fsm_state <= fsm_data;
                    end
                end
                default: begin
                    if (tx_tready && empty) begin
                        fsm_state <= fsm_idle;  // Last word taken
                    end
                end
            endcase
        end
    end

    // Fetch when nothing is shown or the shown beat leaves now
    assign read      = !empty && ((fsm_state == fsm_idle) || tx_tready);
    assign tx_tvalid = (fsm_state == fsm_data);
    assign tx_beat   = read_data;

endmodule

// ==== source/stream_router.sv ====
// Stream router that steers each input beat to the lane queue chosen by tdest
`timescale 1ns/10ps

module stream_router #(
    parameter int lanes = lane_pkg::default_lanes
) (
    input  logic                              rx_tvalid,
    input  stream_pkg::data_t                 rx_tdata,
    input  stream_pkg::dest_t                 rx_tdest,
    input  logic                              rx_tlast,
    output logic                              rx_tready,
    output logic [lanes-1:0]                  q_in_tvalid,
    output stream_pkg::beat_t [lanes-1:0]     q_in_beat,
    input  logic [lanes-1:0]                  q_in_tready
);
    if (lanes < 1 || lanes > lane_pkg::max_lanes) begin : g_lanes_check
        $error("stream_router lanes out of range for tdest width");
    end

    stream_pkg::dest_t sel;                         // Folded lane index
    stream_pkg::beat_t beat;

    // Out of range destinations go to lane 0
    assign sel = (int'(rx_tdest) < lanes) ? rx_tdest : '0;

    always_comb begin
        beat.tdata = rx_tdata;
        beat.tdest = rx_tdest;                      // Carried unchanged
        beat.tlast = rx_tlast;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lane fan-out
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            q_in_tvalid[i] = rx_tvalid && (sel == stream_pkg::dest_t'(i));
            q_in_beat[i]   = beat;                  // Only the valid lane takes it
        end
    end

    assign rx_tready = q_in_tready[sel];

endmodule

// ==== source/stream_switch.sv ====
// Stream switch top level joining the router, the lane queues and the merger
`timescale 1ns/10ps

module stream_switch #(
    parameter int lanes    = lane_pkg::default_lanes,
    parameter int capacity = lane_pkg::default_capacity
) (
    input  logic              aclk,
    input  logic              areset_n,
    input  logic              rx_tvalid,
    output logic              rx_tready,
    input  stream_pkg::data_t rx_tdata,
    input  stream_pkg::dest_t rx_tdest,
    input  logic              rx_tlast,
    output logic              tx_tvalid,
    input  logic              tx_tready,
    output stream_pkg::data_t tx_tdata,
    output stream_pkg::dest_t tx_tdest,
    output logic              tx_tlast
);
    logic [lanes-1:0]              q_in_tvalid;     // Router to queues
    stream_pkg::beat_t [lanes-1:0] q_in_beat;
    logic [lanes-1:0]              q_in_tready;
    logic [lanes-1:0]              q_out_tvalid;    // Queues to merger
    stream_pkg::beat_t [lanes-1:0] q_out_beat;
    logic [lanes-1:0]              q_out_tready;

    stream_router #(
        .lanes(lanes)
    ) router (
        .rx_tvalid   (rx_tvalid),
        .rx_tdata    (rx_tdata),
        .rx_tdest    (rx_tdest),
        .rx_tlast    (rx_tlast),
        .rx_tready   (rx_tready),
        .q_in_tvalid (q_in_tvalid),
        .q_in_beat   (q_in_beat),
        .q_in_tready (q_in_tready)
    );

    // One queue per lane
    for (genvar i = 0; i < lanes; i++) begin : g_lane
        stream_queue #(
            .capacity(capacity)
        ) queue (
            .aclk      (aclk),
            .areset_n  (areset_n),
            .rx_tvalid (q_in_tvalid[i]),
            .rx_beat   (q_in_beat[i]),
            .rx_tready (q_in_tready[i]),
            .tx_tvalid (q_out_tvalid[i]),
            .tx_beat   (q_out_beat[i]),
            .tx_tready (q_out_tready[i])
        );
    end

    stream_merger #(
        .lanes(lanes)
    ) merger (
        .aclk         (aclk),
        .areset_n     (areset_n),
        .q_out_tvalid (q_out_tvalid),
        .q_out_beat   (q_out_beat),
        .q_out_tready (q_out_tready),
        .tx_tvalid    (tx_tvalid),
        .tx_tdata     (tx_tdata),
        .tx_tdest     (tx_tdest),
        .tx_tlast     (tx_tlast),
        .tx_tready    (tx_tready)
    );

endmodule

// ==== test/clock_gen.sv ====
// Testbench clock source with a 10 ns period and a reset held for three cycles
`timescale 1ns/10ps

module clock_gen (
    output logic aclk,
    output logic areset_n
);
    initial begin
        aclk = 1'b0;
        forever #5 aclk = !aclk;
    end

    initial begin
        areset_n = 1'b0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        areset_n = 1'b1;                            // Released on a falling edge
    end

endmodule

// ==== test/stream_switch_properties.sv ====
// Stream switch handshake properties bound to the top level
`timescale 1ns/10ps

module stream_switch_properties (
    input logic              aclk,
    input logic              areset_n,
    input logic              rx_tready,
    input logic              tx_tvalid,
    input logic              tx_tready,
    input stream_pkg::data_t tx_tdata,
    input stream_pkg::dest_t tx_tdest,
    input logic              tx_tlast
);
    logic              pkt_open;                    // Inside an output packet
    stream_pkg::dest_t pkt_dest;

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            pkt_open <= 1'b0;
            pkt_dest <= '0;
        end else if (tx_tvalid && tx_tready) begin
            pkt_open <= !tx_tlast;
            pkt_dest <= tx_tdest;
        end
    end

    tx_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        (tx_tvalid && !tx_tready) |=> (tx_tvalid && $stable(tx_tdata)
            && $stable(tx_tdest) && $stable(tx_tlast)))
        else $error("tx beat changed or dropped before acceptance");

    tx_packet: assert property (@(posedge aclk) disable iff (!areset_n)
        (tx_tvalid && tx_tready && pkt_open) |-> (tx_tdest == pkt_dest))
        else $error("tx packet interleaved with another lane");

    rx_reset: assert property (@(posedge aclk) !areset_n |-> !rx_tready)
        else $error("rx_tready high during reset");

endmodule

bind stream_switch stream_switch_properties props (
    .aclk      (aclk),
    .areset_n  (areset_n),
    .rx_tready (rx_tready),
    .tx_tvalid (tx_tvalid),
    .tx_tready (tx_tready),
    .tx_tdata  (tx_tdata),
    .tx_tdest  (tx_tdest),
    .tx_tlast  (tx_tlast)
);

// ==== test/stream_switch_tb.sv ====
// Stream switch testbench with directed tests against a per-lane reference model
`timescale 1ns/10ps

module stream_switch_tb;
    logic              aclk;
    logic              areset_n;
    logic              rx_tvalid;
    logic              rx_tready;
    stream_pkg::data_t rx_tdata;
    stream_pkg::dest_t rx_tdest;
    logic              rx_tlast;
    logic              tx_tvalid;
    logic              tx_tready;
    stream_pkg::data_t tx_tdata;
    stream_pkg::dest_t tx_tdest;
    logic              tx_tlast;

    int                lanes;
    int                capacity;
    int                cycles      = 0;
    int                cycle_limit = 0;            // Zero until the tests are sized
    logic [15:0]       lfsr_state  = 16'd47;
    logic              stall_en    = 1'b0;
    logic              pkt_open    = 1'b0;
    stream_pkg::dest_t pkt_dest;
    stream_pkg::beat_t model_q [lane_pkg::max_lanes][$]; // Expected beats per lane

    clock_gen clk_gen (.aclk(aclk), .areset_n(areset_n));

    stream_switch dut (
        .aclk(aclk), .areset_n(areset_n),
        .rx_tvalid(rx_tvalid), .rx_tready(rx_tready), .rx_tdata(rx_tdata),
        .rx_tdest(rx_tdest), .rx_tlast(rx_tlast),
        .tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .tx_tdata(tx_tdata),
        .tx_tdest(tx_tdest), .tx_tlast(tx_tlast)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic int rand_bits(input int n);
        int   r;
        logic fb;
        r = 0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = (r << 1) | int'(fb);
        end
        return r;
    endfunction

    function automatic int fold_lane(input stream_pkg::dest_t d);
        return (int'(d) < lanes) ? int'(d) : 0;    // Out of range goes to lane 0
    endfunction

    function automatic int queued();
        int n;
        n = 0;
        for (int l = 0; l < lane_pkg::max_lanes; l++) begin
            n += model_q[l].size();
        end
        return n;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stream switch run stopped");
    endtask

    task automatic compare_beat(input string name, input stream_pkg::beat_t got,
                                input stream_pkg::beat_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic compare_dest(input string name, input stream_pkg::dest_t got,
                                input stream_pkg::dest_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model, monitor and timeout
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_output();
        stream_pkg::beat_t got;
        int                lane;
        got.tdata = tx_tdata;
        got.tdest = tx_tdest;
        got.tlast = tx_tlast;
        lane      = fold_lane(tx_tdest);
        if (model_q[lane].size() == 0) begin
            fail_run($sformatf("output beat for lane %0d arrived with none expected", lane));
        end else begin
            compare_beat("tx_beat", got, model_q[lane].pop_front());
        end
        if (pkt_open) begin
            compare_dest("tx_tdest", tx_tdest, pkt_dest); // Packet must not interleave
        end
        pkt_open = !tx_tlast;
        pkt_dest = tx_tdest;
    endtask

    // Sample just before the rising edge where all signals are settled
    always begin
        stream_pkg::beat_t b;
        @(negedge aclk);
        #4;
        if (areset_n) begin
            if (rx_tvalid && rx_tready) begin
                b.tdata = rx_tdata;
                b.tdest = rx_tdest;
                b.tlast = rx_tlast;
                model_q[fold_lane(rx_tdest)].push_back(b);
            end
            if (tx_tvalid && tx_tready) begin
                check_output();
            end
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            fail_run($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
        end
    end

    always @(negedge aclk) begin
        if (stall_en) begin
            tx_tready = (rand_bits(2) != 0);        // Ready three times in four
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_beat(input int dest, input stream_pkg::data_t data, input logic last);
        logic acc;
        rx_tvalid = 1'b1;
        rx_tdata  = data;
        rx_tdest  = stream_pkg::dest_t'(dest);
        rx_tlast  = last;
        acc       = 1'b0;
        while (!acc) begin
            #4;
            acc = rx_tready;
            @(negedge aclk);
        end
        rx_tvalid = 1'b0;
    endtask

    task automatic send_packet(input int dest, input int len);
        for (int i = 0; i < len; i++) begin
            send_beat(dest, stream_pkg::data_t'(rand_bits(32)), i == len - 1);
        end
    endtask

    task automatic wait_drain();
        while (queued() != 0) begin
            @(negedge aclk);
        end
        repeat (2) @(negedge aclk);
    endtask

    task automatic test_reset();
        do begin
            @(negedge aclk);
            #1;
            compare_bit("tx_tvalid", tx_tvalid, 1'b0);
            compare_bit("rx_tready", rx_tready, 1'b0);
        end while (!areset_n);
        @(negedge aclk);                            // One cycle after release
        compare_bit("tx_tvalid", tx_tvalid, 1'b0);
        compare_bit("rx_tready", rx_tready, 1'b1);
    endtask

    task automatic test_routing();
        for (int l = 0; l < lanes; l++) begin
            send_beat(l, stream_pkg::data_t'(rand_bits(32)), 1'b1);
        end
        wait_drain();
    endtask

    task automatic test_lane_order();
        for (int p = 0; p < 4; p++) begin
            send_packet(lanes - 1, 1 + 2 * rand_bits(1));
        end
        wait_drain();
    endtask

    task automatic test_no_interleave();
        for (int b = 0; b < 4; b++) begin
            for (int l = 0; l < lanes; l++) begin
                send_beat(l, stream_pkg::data_t'(rand_bits(32)), b == 3);
            end
        end
        wait_drain();
    endtask

    task automatic test_backpressure();
        stall_en = 1'b1;
        for (int p = 0; p < 12; p++) begin
            send_packet(rand_bits(2), 1 + rand_bits(2));
        end
        stall_en = 1'b0;
        @(negedge aclk);
        tx_tready = 1'b1;
        wait_drain();
    endtask

    task automatic test_full_queue();
        int accepted;
        int low_run;
        accepted  = 0;
        low_run   = 0;
        tx_tready = 1'b0;
        rx_tvalid = 1'b1;
        rx_tdest  = stream_pkg::dest_t'(lanes - 1);
        rx_tlast  = 1'b1;
        rx_tdata  = stream_pkg::data_t'(rand_bits(32));
        while (low_run < 8) begin
            #4;
            if (rx_tready) begin
                accepted++;
                low_run = 0;
                @(negedge aclk);
                rx_tdata = stream_pkg::data_t'(rand_bits(32));
            end else begin
                low_run++;
                @(negedge aclk);
            end
        end
        rx_tvalid = 1'b0;
        // Memory holds capacity beats and the output register one more
        if (accepted > capacity + 1 || accepted < capacity - 2) begin
            fail_run($sformatf("full queue accepted %0d beats with capacity %0d",
                               accepted, capacity));
        end
        tx_tready = 1'b1;
        wait_drain();
    endtask

    initial begin
        rx_tvalid   = 1'b0;
        rx_tdata    = '0;
        rx_tdest    = '0;
        rx_tlast    = 1'b0;
        tx_tready   = 1'b0;
        lanes       = dut.lanes;
        capacity    = dut.capacity;
        // Beats of all tests, each allowed capacity plus 8 cycles
        cycle_limit = (5 * lanes + 12 + 48 + capacity + 1) * (capacity + 8) + 50;
        test_reset();
        tx_tready = 1'b1;
        test_routing();
        test_lane_order();
        test_no_interleave();
        test_backpressure();
        test_full_queue();
        if (queued() != 0) begin
            fail_run($sformatf("%0d expected beats never came out", queued()));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule
